// ==== build.f ====
+incdir+hw
+incdir+tests
hw/csr_pkg.sv
hw/retire_pkg.sv
hw/csr_ifs.sv
hw/retire_lane.sv
hw/trap_commit.sv
hw/csr_regfile.sv
hw/csr_unit.sv
tests/tb_csr_unit.sv

// ==== Makefile ====
TOP := tb_csr_unit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f build.f --Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing --top-module csr_unit -f build.f

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_csr_tasks.svh ====
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

task automatic csr_ops();
  csr_op_e     ops [6];
  logic [63:0] model;
  logic [63:0] val;
  logic [63:0] imm;
  // MXL 2 with letters A, I, M, S and U
  logic [63:0] misa_exp;
  ops      = '{e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi, e_csrrci};
  misa_exp = (64'd2 << 62) | (64'd1 << 0) | (64'd1 << 8) | (64'd1 << 12)
           | (64'd1 << 18) | (64'd1 << 20);
  rng   = xorshift64(rng);
  model = rng;
  csr_access(e_csrrw, e_csr_mscratch, model);
  for (int i = 0; i < 6; i++)
  begin
    rng = xorshift64(rng);
    val = rng;
    imm = {59'd0, val[4:0]};
    csr_access(ops[i], e_csr_mscratch, val);
    check_hex("csr_illegal_o", 64'(got_illegal), 64'd0);
    check_hex("csr_rdata_o old mscratch", got_rdata, model);
    case (ops[i])
      e_csrrw:  model = val;
      e_csrrs:  model = model | val;
      e_csrrc:  model = model & ~val;
      e_csrrwi: model = imm;
      e_csrrsi: model = model | imm;
      default:  model = model & ~imm;
    endcase
    read_expect("mscratch", e_csr_mscratch, model);
  end
  read_expect("mhartid", e_csr_mhartid, hart_id);
  read_expect("misa", e_csr_misa, misa_exp);
  read_expect("marchid", e_csr_marchid, 64'd13);
endtask

task automatic illegal_access();
  csr_access(e_csrr, 12'h3ff, '0);
  check_hex("csr_illegal_o unknown address", 64'(got_illegal), 64'd1);
  tvec_val = 64'h0000_0000_8000_0103;
  csr_access(e_csrrw, e_csr_mtvec, tvec_val);
  csr_access(e_csrrw, e_csr_mepc, 64'h0000_0000_0000_2000);
  // mpp is still U from reset
  retire_slots(2'b01, 2'b00, 2'b01, 16'h0000, 39'h00_0000_1000, 32'h3020_0073);
  check_hex("redirect_v_o", 64'(got_redir), 64'd1);
  check_hex("redirect_pc_o", 64'(got_rpc), 64'h2000);
  check_hex("priv_o", 64'(priv), 64'(e_priv_u));
  csr_access(e_csrr, e_csr_mstatus, '0);
  check_hex("csr_illegal_o mstatus in U", 64'(got_illegal), 64'd1);
  csr_access(e_csrr, e_csr_cycle, '0);
  check_hex("csr_illegal_o cycle in U", 64'(got_illegal), 64'd0);
endtask

task automatic exception_trap();
  logic [`CSR_VADDR_W-1:0] pc;
  logic [31:0]             instr;
  pc    = 39'h00_0040_1000;
  rng   = xorshift64(rng);
  instr = rng[31:0];
  // Illegal instruction and ecall from U together
  retire_slots(2'b11, 2'b00, 2'b00, 16'h0104, pc, instr);
  check_hex("redirect_v_o", 64'(got_redir), 64'd1);
  check_hex("redirect_pc_o", 64'(got_rpc), 64'(tvec_val[`CSR_VADDR_W-1:0] & ~39'd3));
  check_hex("commit_v_o", 64'(got_commit), 64'h1);
  check_hex("priv_o", 64'(priv), 64'(e_priv_m));
  read_expect("mcause", e_csr_mcause, 64'd2);
  read_expect("mepc", e_csr_mepc, {25'd0, pc});
  read_expect("mtval", e_csr_mtval, {32'd0, instr});
  csr_access(e_csrr, e_csr_mstatus, '0);
  check_hex("mstatus.mpp", 64'(got_rdata[12:11]), 64'(e_priv_u));
  // The earlier mret left mie clear and mpie set
  check_hex("mstatus.mpie", 64'(got_rdata[7]), 64'd0);
endtask

task automatic mret_return();
  logic [63:0] mst_w;
  logic [63:0] epc;
  mst_w = 64'h0000_0000_0000_1808;
  epc   = 64'h0000_0000_0040_1800;
  csr_access(e_csrrw, e_csr_mstatus, mst_w);
  csr_access(e_csrrw, e_csr_mepc, epc);
  retire_slots(2'b11, 2'b00, 2'b01, 16'h0000, 39'h00_0040_2000, 32'h3020_0073);
  check_hex("redirect_v_o", 64'(got_redir), 64'd1);
  check_hex("redirect_pc_o", 64'(got_rpc), 64'(epc[`CSR_VADDR_W-1:0]));
  check_hex("commit_v_o", 64'(got_commit), 64'h1);
  check_hex("priv_o", 64'(priv), 64'(mst_w[12:11]));
  csr_access(e_csrr, e_csr_mstatus, '0);
  check_hex("mstatus.mie", 64'(got_rdata[3]), 64'(mst_w[7]));
  check_hex("mstatus.mpie", 64'(got_rdata[7]), 64'd1);
  check_hex("mstatus.mpp", 64'(got_rdata[12:11]), 64'(e_priv_u));
endtask

task automatic interrupt_take();
  logic [`CSR_VADDR_W-1:0] pc;
  pc = 39'h00_0040_3000;
  csr_access(e_csrrw, e_csr_mie, (64'd1 << 3) | (64'd1 << 7));
  // mret left mstatus.mie clear
  csr_access(e_csrrsi, e_csr_mstatus, 64'd8);
  // External line is raised but not enabled
  m_external_irq = 1'b1;
  next_cycle();
  check_hex("irq_pending_o mei disabled", 64'(irq_pending), 64'd0);
  timer_irq    = 1'b1;
  software_irq = 1'b1;
  next_cycle();
  check_hex("irq_pending_o", 64'(irq_pending), 64'd1);
  csr_access(e_csrrci, e_csr_mstatus, 64'd8);
  check_hex("irq_pending_o mstatus.mie clear", 64'(irq_pending), 64'd0);
  csr_access(e_csrrsi, e_csr_mstatus, 64'd8);
  check_hex("irq_pending_o mstatus.mie set", 64'(irq_pending), 64'd1);
  retire_slots(2'b11, 2'b10, 2'b00, 16'h0000, pc, 32'h0000_0013);
  check_hex("commit_v_o", 64'(got_commit), 64'h3);
  check_hex("redirect_v_o", 64'(got_redir), 64'd1);
  check_hex("redirect_pc_o", 64'(got_rpc), 64'(tvec_val[`CSR_VADDR_W-1:0] & ~39'd3));
  check_hex("irq_pending_o after trap", 64'(irq_pending), 64'd0);
  timer_irq      = 1'b0;
  software_irq   = 1'b0;
  m_external_irq = 1'b0;
  // msi outranks mti
  read_expect("mcause", e_csr_mcause, (64'd1 << 63) | 64'd3);
  read_expect("mepc", e_csr_mepc, {25'd0, pc + 39'd4});
endtask

task automatic counter_updates();
  logic [63:0] c0;
  logic [63:0] i0;
  int          t0;
  csr_access(e_csrr, e_csr_mcycle, '0);
  c0 = got_rdata;
  t0 = sample_cycle;
  repeat (7) next_cycle();
  csr_access(e_csrr, e_csr_mcycle, '0);
  check_hex("mcycle delta", got_rdata - c0, 64'(sample_cycle - t0));
  csr_access(e_csrr, e_csr_minstret, '0);
  i0 = got_rdata;
  retire_slots(2'b11, 2'b00, 2'b00, 16'h0000, 39'h00_0040_4000, 32'h0000_0013);
  check_hex("commit_v_o no trap", 64'(got_commit), 64'h3);
  check_hex("redirect_v_o no trap", 64'(got_redir), 64'd0);
  retire_slots(2'b01, 2'b00, 2'b00, 16'h0000, 39'h00_0040_4008, 32'h0000_0013);
  read_expect("minstret", e_csr_minstret, i0 + 64'd3);
  // Inhibit both counters
  csr_access(e_csrrwi, e_csr_mcountinhibit, 64'd5);
  csr_access(e_csrr, e_csr_mcycle, '0);
  c0 = got_rdata;
  repeat (5) next_cycle();
  read_expect("mcycle inhibited", e_csr_mcycle, c0);
  csr_access(e_csrr, e_csr_minstret, '0);
  i0 = got_rdata;
  retire_slots(2'b11, 2'b00, 2'b00, 16'h0000, 39'h00_0040_5000, 32'h0000_0013);
  read_expect("minstret inhibited", e_csr_minstret, i0);
  csr_access(e_csrrwi, e_csr_mcountinhibit, 64'd0);
endtask

`endif

// ==== tests/tb_csr_unit.sv ====
`include "csr_cfg.svh"

module tb_csr_unit
  import csr_pkg::*;
  import retire_pkg::*;
();

  localparam int clk_period = 40;
  // Directed tests need about a hundred cycles
  localparam int cycle_limit = 2000;
  localparam logic [63:0] hart_id = 64'h0000_0000_0000_0005;

  logic                                          clk;
  logic                                          rst_n;
  logic                                          csr_cmd_v;
  csr_op_e                                       csr_op;
  logic [11:0]                                   csr_addr;
  logic [`CSR_XLEN-1:0]                          csr_wdata;
  logic                                          timer_irq;
  logic                                          software_irq;
  logic                                          m_external_irq;
  logic [`CSR_NUM_LANES-1:0]                     retire_v;
  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]   retire_pc;
  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]   retire_npc;
  logic [`CSR_NUM_LANES-1:0][31:0]               retire_instr;
  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]   retire_vaddr;
  retire_exc_s [`CSR_NUM_LANES-1:0]              retire_exc;
  logic [`CSR_NUM_LANES-1:0]                     retire_irq;
  logic [`CSR_NUM_LANES-1:0]                     retire_mret;
  logic [`CSR_XLEN-1:0]                          csr_rdata;
  logic                                          csr_illegal;
  priv_e                                         priv;
  logic                                          irq_pending;
  logic [`CSR_NUM_LANES-1:0]                     commit_v;
  logic                                          redirect_v;
  logic [`CSR_VADDR_W-1:0]                       redirect_pc;

  int                      err_cnt;
  int                      check_cnt;
  int                      cycle_cnt = 0;
  int                      sample_cycle;
  logic [63:0]             rng;
  logic [63:0]             tvec_val;
  logic [63:0]             got_rdata;
  logic                    got_illegal;
  logic [1:0]              got_commit;
  logic                    got_redir;
  logic [`CSR_VADDR_W-1:0] got_rpc;

  csr_unit uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .csr_cmd_v_i      (csr_cmd_v),
    .csr_op_i         (csr_op),
    .csr_addr_i       (csr_addr),
    .csr_wdata_i      (csr_wdata),
    .hart_id_i        (hart_id),
    .timer_irq_i      (timer_irq),
    .software_irq_i   (software_irq),
    .m_external_irq_i (m_external_irq),
    .retire_v_i       (retire_v),
    .retire_pc_i      (retire_pc),
    .retire_npc_i     (retire_npc),
    .retire_instr_i   (retire_instr),
    .retire_vaddr_i   (retire_vaddr),
    .retire_exc_i     (retire_exc),
    .retire_irq_i     (retire_irq),
    .retire_mret_i    (retire_mret),
    .csr_rdata_o      (csr_rdata),
    .csr_illegal_o    (csr_illegal),
    .priv_o           (priv),
    .irq_pending_o    (irq_pending),
    .commit_v_o       (commit_v),
    .redirect_v_o     (redirect_v),
    .redirect_pc_o    (redirect_pc)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout, the tests did not complete within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // One command cycle with the write landing at the closing edge
  task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                            input logic [63:0] wdata);
    csr_cmd_v = 1'b1;
    csr_op    = op;
    csr_addr  = addr;
    csr_wdata = wdata;
    #20;
    got_rdata    = csr_rdata;
    got_illegal  = csr_illegal;
    sample_cycle = cycle_cnt;
    next_cycle();
    csr_cmd_v = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [11:0] addr,
                             input logic [63:0] exp);
    csr_access(e_csrr, addr, '0);
    check_hex({name, " illegal"}, 64'(got_illegal), 64'd0);
    check_hex(name, got_rdata, exp);
  endtask

  // Slot 1 follows slot 0 in program order
  task automatic retire_slots(input logic [1:0] v, input logic [1:0] irq,
                              input logic [1:0] mret, input logic [15:0] exc0,
                              input logic [`CSR_VADDR_W-1:0] pc, input logic [31:0] instr);
    retire_v        = v;
    retire_irq      = irq;
    retire_mret     = mret;
    retire_exc[0]   = retire_exc_s'(exc0);
    retire_exc[1]   = '0;
    retire_pc[0]    = pc;
    retire_npc[0]   = pc + 39'd4;
    retire_pc[1]    = pc + 39'd4;
    retire_npc[1]   = pc + 39'd8;
    retire_vaddr[0] = pc;
    retire_vaddr[1] = pc + 39'd4;
    retire_instr[0] = instr;
    retire_instr[1] = 32'h0000_0013;
    #20;
    got_commit = commit_v;
    got_redir  = redirect_v;
    got_rpc    = redirect_pc;
    next_cycle();
    retire_v    = '0;
    retire_irq  = '0;
    retire_mret = '0;
    retire_exc  = '0;
  endtask

  `include "tb_csr_tasks.svh"

  initial
  begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    csr_cmd_v      = 1'b0;
    csr_op         = e_csrr;
    csr_addr       = '0;
    csr_wdata      = '0;
    timer_irq      = 1'b0;
    software_irq   = 1'b0;
    m_external_irq = 1'b0;
    retire_v       = '0;
    retire_pc      = '0;
    retire_npc     = '0;
    retire_instr   = '0;
    retire_vaddr   = '0;
    retire_exc     = '0;
    retire_irq     = '0;
    retire_mret    = '0;
    err_cnt        = 0;
    check_cnt      = 0;
    tvec_val       = '0;
    rng            = 64'd30728;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    csr_ops();
    illegal_access();
    exception_trap();
    mret_return();
    interrupt_take();
    counter_updates();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== hw/csr_unit.sv ====
`include "csr_cfg.svh"

module csr_unit
  import csr_pkg::*;
  import retire_pkg::*;
(
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         csr_cmd_v_i,
  input  csr_op_e                                      csr_op_i,
  input  logic [11:0]                                  csr_addr_i,
  input  logic [`CSR_XLEN-1:0]                         csr_wdata_i,
  input  logic [`CSR_XLEN-1:0]                         hart_id_i,
  input  logic                                         timer_irq_i,
  input  logic                                         software_irq_i,
  input  logic                                         m_external_irq_i,
  input  logic [`CSR_NUM_LANES-1:0]                    retire_v_i,
  input  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]  retire_pc_i,
  input  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]  retire_npc_i,
  input  logic [`CSR_NUM_LANES-1:0][31:0]              retire_instr_i,
  input  logic [`CSR_NUM_LANES-1:0][`CSR_VADDR_W-1:0]  retire_vaddr_i,
  input  retire_exc_s [`CSR_NUM_LANES-1:0]             retire_exc_i,
  input  logic [`CSR_NUM_LANES-1:0]                    retire_irq_i,
  input  logic [`CSR_NUM_LANES-1:0]                    retire_mret_i,
  output logic [`CSR_XLEN-1:0]                         csr_rdata_o,
  output logic                                         csr_illegal_o,
  output priv_e                                        priv_o,
  output logic                                         irq_pending_o,
  output logic [`CSR_NUM_LANES-1:0]                    commit_v_o,
  output logic                                         redirect_v_o,
  output logic [`CSR_VADDR_W-1:0]                      redirect_pc_o
);

  lane_ctx_if   ctx_if [`CSR_NUM_LANES] ();
  lane_trap_if  trap_if [`CSR_NUM_LANES] ();
  csr_update_if upd_if ();

  csr_regfile u_regfile (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .csr_cmd_v_i      (csr_cmd_v_i),
    .csr_op_i         (csr_op_i),
    .csr_addr_i       (csr_addr_i),
    .csr_wdata_i      (csr_wdata_i),
    .hart_id_i        (hart_id_i),
    .timer_irq_i      (timer_irq_i),
    .software_irq_i   (software_irq_i),
    .m_external_irq_i (m_external_irq_i),
    .csr_rdata_o      (csr_rdata_o),
    .csr_illegal_o    (csr_illegal_o),
    .priv_o           (priv_o),
    .irq_pending_o    (irq_pending_o),
    .ctx              (ctx_if),
    .upd              (upd_if)
  );

  // Slot 0 holds the older instruction
  for (genvar i = 0; i < `CSR_NUM_LANES; i++)
  begin : g_lane
    retire_lane u_lane (
      .retire_v_i     (retire_v_i[i]),
      .retire_pc_i    (retire_pc_i[i]),
      .retire_npc_i   (retire_npc_i[i]),
      .retire_instr_i (retire_instr_i[i]),
      .retire_vaddr_i (retire_vaddr_i[i]),
      .retire_exc_i   (retire_exc_i[i]),
      .retire_irq_i   (retire_irq_i[i]),
      .retire_mret_i  (retire_mret_i[i]),
      .ctx            (ctx_if[i]),
      .trap           (trap_if[i])
    );
  end

  trap_commit u_commit (
    .trap          (trap_if),
    .upd           (upd_if),
    .commit_v_o    (commit_v_o),
    .redirect_v_o  (redirect_v_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

// ==== hw/csr_regfile.sv ====
`include "csr_cfg.svh"

module csr_regfile
  import csr_pkg::*;
  import retire_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 csr_cmd_v_i,
  input  csr_op_e              csr_op_i,
  input  logic [11:0]          csr_addr_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  input  logic [`CSR_XLEN-1:0] hart_id_i,
  input  logic                 timer_irq_i,
  input  logic                 software_irq_i,
  input  logic                 m_external_irq_i,
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  output logic                 csr_illegal_o,
  output priv_e                priv_o,
  output logic                 irq_pending_o,
  lane_ctx_if.source           ctx [`CSR_NUM_LANES],
  csr_update_if.sink           upd
);

  localparam irq_bits_s irq_mask = '{msi: 1'b1, mti: 1'b1, mei: 1'b1, default: '0};

  priv_e                   priv_r, priv_n;
  mstatus_s                mstatus_r, mstatus_n;
  irq_bits_s               mie_r, mie_n, mip_r, mip_n;
  cause_s                  mcause_r, mcause_n;
  logic [`CSR_VADDR_W-1:0] mepc_r, mepc_n;
  logic [`CSR_XLEN-1:0]    mtvec_r, mtvec_n, mscratch_r, mscratch_n, mtval_r, mtval_n;
  logic [`CSR_XLEN-1:0]    mcycle_r, mcycle_n, minstret_r, minstret_n;
  logic [`CSR_XLEN-1:0]    mcountinhibit_r, mcountinhibit_n;

  logic [`CSR_XLEN-1:0]    rdata, src, wval, mepc_ext;
  logic                    unknown, wr_v, gie, irq_v;
  irq_bits_s               pend;
  logic [3:0]              irq_code;

  assign mepc_ext = {{(`CSR_XLEN-`CSR_VADDR_W){mepc_r[`CSR_VADDR_W-1]}}, mepc_r};

  always_comb
  begin
    unknown = 1'b0;
    rdata   = '0;
    case (csr_addr_i)
      e_csr_cycle, e_csr_mcycle:     rdata = mcycle_r;
      e_csr_instret, e_csr_minstret: rdata = minstret_r;
      e_csr_mstatus:       rdata = mstatus_r;
      e_csr_misa:          rdata = `CSR_MISA_VAL;
      e_csr_mie:           rdata = mie_r;
      e_csr_mip:           rdata = mip_r;
      e_csr_mtvec:         rdata = mtvec_r;
      e_csr_mcountinhibit: rdata = mcountinhibit_r;
      e_csr_mscratch:      rdata = mscratch_r;
      e_csr_mepc:          rdata = mepc_ext;
      e_csr_mcause:        rdata = mcause_r;
      e_csr_mtval:         rdata = mtval_r;
      e_csr_marchid:       rdata = `CSR_MARCHID_VAL;
      e_csr_mimpid:        rdata = `CSR_MIMPID_VAL;
      e_csr_mhartid:       rdata = hart_id_i;
      default:             unknown = 1'b1;
    endcase
  end

  // Address bits 9:8 hold the lowest privilege allowed
  assign csr_illegal_o = csr_cmd_v_i & (unknown | (csr_addr_i[9:8] > priv_r));
  assign csr_rdata_o   = rdata;
  assign wr_v          = csr_cmd_v_i & ~csr_illegal_o & (csr_op_i != e_csrr);

  always_comb
  begin
    src = csr_op_i[2] ? {{(`CSR_XLEN-5){1'b0}}, csr_wdata_i[4:0]} : csr_wdata_i;
    case (csr_op_i)
      e_csrrw, e_csrrwi: wval = src;
      e_csrrs, e_csrrsi: wval = rdata | src;
      e_csrrc, e_csrrci: wval = rdata & ~src;
      default:           wval = rdata;
    endcase
  end

  always_comb
  begin
    priv_n          = priv_r;
    mstatus_n       = mstatus_r;
    mie_n           = mie_r;
    mtvec_n         = mtvec_r;
    mscratch_n      = mscratch_r;
    mepc_n          = mepc_r;
    mcause_n        = mcause_r;
    mtval_n         = mtval_r;
    mcountinhibit_n = mcountinhibit_r;
    mip_n           = '0;
    mip_n.msi       = software_irq_i;
    mip_n.mti       = timer_irq_i;
    mip_n.mei       = m_external_irq_i;
    mcycle_n   = mcountinhibit_r[0] ? mcycle_r : mcycle_r + `CSR_XLEN'(1);
    minstret_n = mcountinhibit_r[2] ? minstret_r
                                    : minstret_r + `CSR_XLEN'(upd.instret_count);

    // misa, mhartid and mip ignore writes
    if (wr_v)
    begin
      case (csr_addr_i)
        e_csr_mstatus:
        begin
          mstatus_n.mie  = wval[3];
          mstatus_n.mpie = wval[7];
          mstatus_n.mpp  = (wval[12:11] == 2'b11) ? e_priv_m : e_priv_u;
        end
        e_csr_mcause:
        begin
          mcause_n.intr = wval[`CSR_XLEN-1];
          mcause_n.code = wval[3:0];
        end
        e_csr_mie:           mie_n = irq_bits_s'(wval & irq_mask);
        e_csr_mtvec:         mtvec_n = wval;
        e_csr_mscratch:      mscratch_n = wval;
        e_csr_mepc:          mepc_n = wval[`CSR_VADDR_W-1:0];
        e_csr_mtval:         mtval_n = wval;
        e_csr_mcycle:        mcycle_n = wval;
        e_csr_minstret:      minstret_n = wval;
        e_csr_mcountinhibit: mcountinhibit_n = wval & `CSR_XLEN'(5);
        default:             ;
      endcase
    end

    // Retire updates override the command write
    if (upd.trap_v)
    begin
      priv_n         = e_priv_m;
      mstatus_n.mpp  = priv_r;
      mstatus_n.mpie = mstatus_r.mie;
      mstatus_n.mie  = 1'b0;
      mepc_n         = upd.epc;
      mcause_n       = upd.cause;
      mtval_n        = upd.tval;
    end
    else if (upd.mret_v)
    begin
      priv_n         = mstatus_r.mpp;
      mstatus_n.mie  = mstatus_r.mpie;
      mstatus_n.mpie = 1'b1;
      mstatus_n.mpp  = e_priv_u;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      priv_r          <= priv_e'(`CSR_RESET_PRIV);
      mstatus_r       <= '0;
      mie_r           <= '0;
      mip_r           <= '0;
      mtvec_r         <= '0;
      mepc_r          <= '0;
      mcause_r        <= '0;
      mtval_r         <= '0;
      mcycle_r        <= '0;
      minstret_r      <= '0;
      mcountinhibit_r <= '0;
    end
    else
    begin
      priv_r          <= priv_n;
      mstatus_r       <= mstatus_n;
      mie_r           <= mie_n;
      mip_r           <= mip_n;
      mtvec_r         <= mtvec_n;
      mepc_r          <= mepc_n;
      mcause_r        <= mcause_n;
      mtval_r         <= mtval_n;
      mcycle_r        <= mcycle_n;
      minstret_r      <= minstret_n;
      mcountinhibit_r <= mcountinhibit_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    mscratch_r <= mscratch_n;
  end

  // U mode always takes machine interrupts
  assign pend  = irq_bits_s'(mie_r & mip_r);
  assign gie   = (priv_r == e_priv_m) ? mstatus_r.mie : 1'b1;
  assign irq_v = gie & (pend.msi | pend.mti | pend.mei);
  assign irq_code = pend.msi ? 4'd3 : (pend.mti ? 4'd7 : 4'd11);

  assign irq_pending_o = irq_v;
  assign priv_o        = priv_r;

  for (genvar i = 0; i < `CSR_NUM_LANES; i++)
  begin : g_ctx
    assign ctx[i].tvec_base  = {mtvec_r[`CSR_VADDR_W-1:2], 2'b00};
    assign ctx[i].mepc       = mepc_r;
    assign ctx[i].priv       = priv_r;
    assign ctx[i].irq_take_v = irq_v;
    assign ctx[i].irq_code   = irq_code;
  end

  trap_excludes_mret: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    upd.trap_v |-> !upd.mret_v)
    else $error("csr_regfile: trap and mret update in the same cycle");

endmodule

// ==== hw/trap_commit.sv ====
`include "csr_cfg.svh"

module trap_commit
  import retire_pkg::*;
(
  lane_trap_if.sink                 trap [`CSR_NUM_LANES],
  csr_update_if.source              upd,
  output logic [`CSR_NUM_LANES-1:0] commit_v_o,
  output logic                      redirect_v_o,
  output logic [`CSR_VADDR_W-1:0]   redirect_pc_o
);

  localparam int lanes = `CSR_NUM_LANES;
  localparam int cnt_w = $clog2(lanes + 1);

  logic [lanes-1:0]        valid;
  logic [lanes-1:0]        instret;
  trap_kind_e              kind [lanes];
  cause_s                  cause [lanes];
  logic [`CSR_VADDR_W-1:0] epc [lanes];
  logic [`CSR_VADDR_W-1:0] npc [lanes];
  logic [`CSR_XLEN-1:0]    tval [lanes];
  logic [cnt_w-1:0]        cnt;
  logic                    hit;
  int                      sel;

  for (genvar i = 0; i < lanes; i++)
  begin : g_lane
    assign valid[i]   = trap[i].valid;
    assign instret[i] = trap[i].instret;
    assign kind[i]    = trap[i].kind;
    assign cause[i]   = trap[i].cause;
    assign epc[i]     = trap[i].epc;
    assign npc[i]     = trap[i].npc;
    assign tval[i]    = trap[i].tval;
  end

  // Oldest first; the first trap or mret kills the younger slots
  always_comb
  begin
    commit_v_o = '0;
    hit        = 1'b0;
    sel        = 0;
    cnt        = '0;
    for (int i = 0; i < lanes; i++)
    begin
      if (!hit && valid[i])
      begin
        commit_v_o[i] = 1'b1;
        cnt = cnt + cnt_w'(instret[i]);
        if (kind[i] != e_trap_none)
        begin
          hit = 1'b1;
          sel = i;
        end
      end
    end
  end

  assign redirect_v_o      = hit;
  assign redirect_pc_o     = npc[sel];
  assign upd.trap_v        = hit && (kind[sel] inside {e_trap_exc, e_trap_irq});
  assign upd.mret_v        = hit && (kind[sel] == e_trap_mret);
  assign upd.cause         = cause[sel];
  assign upd.epc           = epc[sel];
  assign upd.tval          = tval[sel];
  assign upd.instret_count = cnt;

  // A trapped or idle slot never counts as retired
  always_comb
  begin
    for (int i = 0; i < lanes; i++)
    begin
      assert (!(instret[i] && (!valid[i] || kind[i] inside {e_trap_exc, e_trap_irq})))
        else $error("trap_commit: slot %0d retires while idle or trapped", i);
    end
  end

endmodule

// ==== hw/retire_lane.sv ====
`include "csr_cfg.svh"

module retire_lane
  import csr_pkg::*;
  import retire_pkg::*;
(
  input  logic                    retire_v_i,
  input  logic [`CSR_VADDR_W-1:0] retire_pc_i,
  input  logic [`CSR_VADDR_W-1:0] retire_npc_i,
  input  logic [31:0]             retire_instr_i,
  input  logic [`CSR_VADDR_W-1:0] retire_vaddr_i,
  input  retire_exc_s             retire_exc_i,
  input  logic                    retire_irq_i,
  input  logic                    retire_mret_i,
  lane_ctx_if.sink                ctx,
  lane_trap_if.source             trap
);

  logic [15:0]          exc_vec;
  logic                 exc_v;
  logic                 mret_bad;
  logic [3:0]           exc_code;
  trap_kind_e           kind;
  cause_s               cause;
  logic [`CSR_XLEN-1:0] vaddr_ext;

  // mret outside M mode is an illegal instruction
  assign mret_bad = retire_mret_i & (ctx.priv != e_priv_m);
  assign exc_vec  = retire_exc_i | {13'b0, mret_bad, 2'b00};
  assign exc_v    = |exc_vec;

  // Lowest set bit wins
  always_comb
  begin
    exc_code = '0;
    for (int i = 15; i >= 0; i--)
    begin
      if (exc_vec[i])
      begin
        exc_code = 4'(i);
      end
    end
  end

  assign kind = !retire_v_i                     ? e_trap_none
              : (retire_irq_i & ctx.irq_take_v) ? e_trap_irq
              : exc_v                           ? e_trap_exc
              : retire_mret_i                   ? e_trap_mret
              :                                   e_trap_none;

  assign cause.intr = (kind == e_trap_irq);
  assign cause.rsvd = '0;
  assign cause.code = (kind == e_trap_irq) ? ctx.irq_code : exc_code;

  assign vaddr_ext = {{(`CSR_XLEN-`CSR_VADDR_W){retire_vaddr_i[`CSR_VADDR_W-1]}},
                      retire_vaddr_i};

  assign trap.valid = retire_v_i;
  assign trap.kind  = kind;
  assign trap.cause = cause;
  assign trap.epc   = retire_pc_i;
  assign trap.tval  = (kind != e_trap_exc) ? '0
                    : (exc_code == 4'd2)   ? {{(`CSR_XLEN-32){1'b0}}, retire_instr_i}
                    :                        vaddr_ext;
  assign trap.npc   = (kind inside {e_trap_exc, e_trap_irq}) ? ctx.tvec_base
                    : (kind == e_trap_mret)                   ? ctx.mepc
                    :                                           retire_npc_i;
  // Trapped instructions do not retire
  assign trap.instret = retire_v_i & (kind inside {e_trap_none, e_trap_mret});

  always_comb
  begin
    assert (retire_v_i || !(retire_irq_i || retire_mret_i || (|retire_exc_i)))
      else $error("retire_lane: trap request on an idle slot");
  end

endmodule

// ==== hw/csr_ifs.sv ====
`include "csr_cfg.svh"

interface lane_ctx_if
  import csr_pkg::*;
();
  logic [`CSR_VADDR_W-1:0] tvec_base;
  logic [`CSR_VADDR_W-1:0] mepc;
  priv_e                   priv;
  logic                    irq_take_v;
  logic [3:0]              irq_code;

  modport source (output tvec_base, mepc, priv, irq_take_v, irq_code);
  modport sink   (input  tvec_base, mepc, priv, irq_take_v, irq_code);
endinterface

interface lane_trap_if
  import retire_pkg::*;
();
  logic                    valid;
  trap_kind_e              kind;
  cause_s                  cause;
  logic [`CSR_VADDR_W-1:0] epc;
  logic [`CSR_XLEN-1:0]    tval;
  logic [`CSR_VADDR_W-1:0] npc;
  logic                    instret;

  modport source (output valid, kind, cause, epc, tval, npc, instret);
  modport sink   (input  valid, kind, cause, epc, tval, npc, instret);
endinterface

interface csr_update_if
  import retire_pkg::*;
();
  logic                                   trap_v;
  logic                                   mret_v;
  cause_s                                 cause;
  logic [`CSR_VADDR_W-1:0]                epc;
  logic [`CSR_XLEN-1:0]                   tval;
  logic [$clog2(`CSR_NUM_LANES+1)-1:0]    instret_count;

  modport source (output trap_v, mret_v, cause, epc, tval, instret_count);
  modport sink   (input  trap_v, mret_v, cause, epc, tval, instret_count);
endinterface

// ==== hw/retire_pkg.sv ====
package retire_pkg;

  // Bit index equals the exception cause code
  typedef struct packed {
    logic store_page_fault;
    logic rsvd_14;
    logic load_page_fault;
    logic instr_page_fault;
    logic ecall_m;
    logic rsvd_10;
    logic ecall_s;
    logic ecall_u;
    logic store_access_fault;
    logic store_misaligned;
    logic load_access_fault;
    logic load_misaligned;
    logic breakpoint;
    logic illegal_instr;
    logic instr_access_fault;
    logic instr_misaligned;
  } retire_exc_s;

  typedef struct packed {
    logic        intr;
    logic [58:0] rsvd;
    logic [3:0]  code;
  } cause_s;

  typedef enum logic [1:0] {
    e_trap_none = 2'b00,
    e_trap_exc  = 2'b01,
    e_trap_irq  = 2'b10,
    e_trap_mret = 2'b11
  } trap_kind_e;

endpackage

// ==== hw/csr_pkg.sv ====
package csr_pkg;

  typedef enum logic [11:0] {
    e_csr_cycle         = 12'hc00,
    e_csr_instret       = 12'hc02,
    e_csr_mstatus       = 12'h300,
    e_csr_misa          = 12'h301,
    e_csr_mie           = 12'h304,
    e_csr_mtvec         = 12'h305,
    e_csr_mcountinhibit = 12'h320,
    e_csr_mscratch      = 12'h340,
    e_csr_mepc          = 12'h341,
    e_csr_mcause        = 12'h342,
    e_csr_mtval         = 12'h343,
    e_csr_mip           = 12'h344,
    e_csr_mcycle        = 12'hb00,
    e_csr_minstret      = 12'hb02,
    e_csr_marchid       = 12'hf12,
    e_csr_mimpid        = 12'hf13,
    e_csr_mhartid       = 12'hf14
  } csr_addr_e;

  // Bit 2 selects the immediate form
  typedef enum logic [2:0] {
    e_csrr   = 3'b000,
    e_csrrw  = 3'b001,
    e_csrrs  = 3'b010,
    e_csrrc  = 3'b011,
    e_csrrwi = 3'b101,
    e_csrrsi = 3'b110,
    e_csrrci = 3'b111
  } csr_op_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_m = 2'b11
  } priv_e;

  typedef struct packed {
    logic [50:0] rsvd_hi;
    priv_e       mpp;
    logic [2:0]  rsvd_mid;
    logic        mpie;
    logic [2:0]  rsvd_lo;
    logic        mie;
    logic [2:0]  rsvd_0;
  } mstatus_s;

  // Layout shared by mie and mip
  typedef struct packed {
    logic [51:0] rsvd_hi;
    logic        mei;
    logic [2:0]  rsvd_b;
    logic        mti;
    logic [2:0]  rsvd_a;
    logic        msi;
    logic [2:0]  rsvd_lo;
  } irq_bits_s;

endpackage

// ==== hw/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN 64
`define CSR_VADDR_W 39
`define CSR_NUM_LANES 2

// MXL 64, letters I M A S U
`define CSR_MISA_VAL 64'h8000_0000_0014_1101
`define CSR_MARCHID_VAL 64'd13
`define CSR_MIMPID_VAL 64'd1

`define CSR_RESET_PRIV 2'b11

`endif
